/* hw/isaPkg.sv */
`default_nettype none

package isaPkg;

	// Five-bit opcodes, codes 00010 and 00011 are left undefined
	typedef enum logic [4:0] {
		HALT  = 5'b00000,
		NOP   = 5'b00001,
		J     = 5'b00100,
		JR    = 5'b00101,
		JAL   = 5'b00110,
		JALR  = 5'b00111,
		ADDI  = 5'b01000,
		SUBI  = 5'b01001,
		XORI  = 5'b01010,
		ANDNI = 5'b01011,
		BEQZ  = 5'b01100,
		BNEZ  = 5'b01101,
		BLTZ  = 5'b01110,
		BGEZ  = 5'b01111,
		ST    = 5'b10000,
		LD    = 5'b10001,
		SLBI  = 5'b10010,
		STU   = 5'b10011,
		ROLI  = 5'b10100,
		SLLI  = 5'b10101,
		RORI  = 5'b10110,
		SRLI  = 5'b10111,
		LBI   = 5'b11000,
		BTR   = 5'b11001,
		SHFR  = 5'b11010,
		ALUR  = 5'b11011,
		SEQ   = 5'b11100,
		SLT   = 5'b11101,
		SLE   = 5'b11110,
		SCO   = 5'b11111
	} opcodeT;

	// Register format
	typedef struct packed {
		opcodeT opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		logic [1:0] funct;
	} rViewT;

	// Immediate format, the 8 and 11-bit fields are the low bits of the word
	typedef struct packed {
		opcodeT opcode;
		logic [2:0] rs;
		logic [2:0] rd;
		logic [4:0] imm5;
	} iViewT;

	typedef union packed {
		rViewT rView;
		iViewT iView;
	} instrU;

	typedef enum logic [2:0] {
		immNone   = 3'd0,
		immSign5  = 3'd1,
		immZero5  = 3'd2,
		immSign8  = 3'd3,
		immZero8  = 3'd4,
		immSign11 = 3'd5
	} immKindT;

	// Low two bits line up with the low opcode bits of the branch and set groups
	typedef enum logic [2:0] {
		brEqz   = 3'd0,
		brNez   = 3'd1,
		brLtz   = 3'd2,
		brGez   = 3'd3,
		brEq    = 3'd4,
		brLt    = 3'd5,
		brLe    = 3'd6,
		brCarry = 3'd7
	} brSelT;

endpackage

`default_nettype wire

/* hw/pipePkg.sv */
`default_nettype none

package pipePkg;

	import isaPkg::*;

	// EX/MEM wins when both are set
	typedef struct packed {
		logic exMem;
		logic memWb;
	} fwdSelT;

	typedef enum logic [2:0] {
		aluRol = 3'd0,
		aluSll = 3'd1,
		aluRor = 3'd2,
		aluSrl = 3'd3,
		aluAdd = 3'd4,
		aluOr  = 3'd5,
		aluXor = 3'd6,
		aluAnd = 3'd7
	} aluOpT;

	// Which instruction field names the write-back register
	typedef enum logic [1:0] {
		dstRd = 2'd0,
		dstRt = 2'd1,
		dstRs = 2'd2,
		dstR7 = 2'd3
	} regDstT;

	typedef struct packed {
		// Memory
		logic memWrite;
		logic memEn;
		logic memToReg;
		logic memDump;
		// ALU
		logic aluSrc2;
		logic invA;
		logic invB;
		logic sign;
		logic cin;
		aluOpT aluOp;
		logic set;
		logic btr;
		logic lbi;
		logic slbi;
		// Program flow
		logic pcSrc;
		logic jump;
		logic pcImm;
		logic pcToReg;
		logic halt;
		// Register write
		regDstT regDst;
		logic regWrite;
		brSelT brSel;
		immKindT immKind;
	} ctrlT;

	typedef struct packed {
		logic [15:0] opA;
		logic [15:0] opB;
		logic [15:0] imm;
		logic [15:0] branchPc;
	} decodeOutT;

endpackage

`default_nettype wire

/* hw/controlDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module controlDecoder import isaPkg::*, pipePkg::*; (
	input  opcodeT     opcode,
	input  logic [1:0] funct,
	output ctrlT       ctrl,
	output logic       err
);

	always_comb begin
		ctrl = '0;
		err = 1'b0;
		case (opcode)
			HALT: begin
				ctrl.halt = 1'b1;
				ctrl.memDump = 1'b1;
			end
			NOP: begin
				// Bundle stays clear
			end
			ADDI, SUBI: begin
				ctrl.aluSrc2 = 1'b1;
				ctrl.aluOp = aluAdd;
				ctrl.sign = 1'b1;
				// SUBI computes imm - rs
				ctrl.invA = (opcode == SUBI);
				ctrl.cin = (opcode == SUBI);
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.immKind = immSign5;
			end
			XORI, ANDNI: begin
				ctrl.aluSrc2 = 1'b1;
				ctrl.aluOp = (opcode == XORI) ? aluXor : aluAnd;
				ctrl.invB = (opcode == ANDNI);
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.immKind = immZero5;
			end
			ROLI, SLLI, RORI, SRLI: begin
				ctrl.aluSrc2 = 1'b1;
				ctrl.aluOp = aluOpT'({1'b0, opcode[1:0]});
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRt;
				ctrl.immKind = immZero5;
			end
			ST, LD, STU: begin
				// Address is rs + imm for all three
				ctrl.memEn = 1'b1;
				ctrl.memWrite = (opcode != LD);
				ctrl.memToReg = (opcode == LD);
				ctrl.aluSrc2 = 1'b1;
				ctrl.aluOp = aluAdd;
				ctrl.sign = 1'b1;
				ctrl.regWrite = (opcode != ST);
				ctrl.regDst = (opcode == STU) ? dstRs : dstRt;
				ctrl.immKind = immSign5;
			end
			BTR: begin
				ctrl.btr = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRd;
			end
			ALUR: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRd;
				case (funct)
					2'b00: ctrl.aluOp = aluAdd;
					2'b01: ctrl.aluOp = aluAdd;
					2'b10: ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluAnd;
				endcase
				// SUB is rt - rs, ANDN inverts the second operand
				ctrl.invA = (funct == 2'b01);
				ctrl.cin = (funct == 2'b01);
				ctrl.invB = (funct == 2'b11);
				ctrl.sign = !funct[1];
			end
			SHFR: begin
				ctrl.aluOp = aluOpT'({1'b0, funct});
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRd;
			end
			SEQ, SLT, SLE, SCO: begin
				ctrl.set = 1'b1;
				ctrl.aluOp = aluAdd;
				ctrl.sign = 1'b1;
				ctrl.invB = (opcode != SCO);
				ctrl.cin = (opcode != SCO);
				ctrl.brSel = brSelT'({1'b1, opcode[1:0]});
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRd;
			end
			BEQZ, BNEZ, BLTZ, BGEZ: begin
				ctrl.pcSrc = 1'b1;
				ctrl.brSel = brSelT'({1'b0, opcode[1:0]});
				ctrl.immKind = immSign8;
			end
			LBI, SLBI: begin
				ctrl.aluSrc2 = 1'b1;
				ctrl.lbi = (opcode == LBI);
				ctrl.slbi = (opcode == SLBI);
				ctrl.aluOp = aluOr;
				ctrl.regWrite = 1'b1;
				ctrl.regDst = dstRs;
				ctrl.immKind = (opcode == LBI) ? immSign8 : immZero8;
			end
			J, JR, JAL, JALR: begin
				ctrl.pcImm = 1'b1;
				// JR and JALR take rs as the target base
				ctrl.jump = opcode[0];
				ctrl.pcToReg = opcode[1];
				ctrl.regWrite = opcode[1];
				ctrl.regDst = opcode[1] ? dstR7 : dstRd;
				ctrl.immKind = opcode[0] ? immSign8 : immSign11;
			end
			default: begin
				err = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/immExtender.sv */
`timescale 1ns/10ps
`default_nettype none

module immExtender import isaPkg::*; (
	input  instrU       instr,
	input  immKindT     immKind,
	output logic [15:0] imm
);

	logic [4:0] imm5;
	logic [7:0] imm8;
	logic [10:0] imm11;

	// Wider fields grow upward from the same low bits
	assign imm5 = instr.iView.imm5;
	assign imm8 = {instr.iView.rd, instr.iView.imm5};
	assign imm11 = {instr.iView.rs, instr.iView.rd, instr.iView.imm5};

	always_comb begin
		case (immKind)
			immSign5: imm = {{11{imm5[4]}}, imm5};
			immZero5: imm = {11'd0, imm5};
			immSign8: imm = {{8{imm8[7]}}, imm8};
			immZero8: imm = {8'd0, imm8};
			immSign11: imm = {{5{imm11[10]}}, imm11};
			default: imm = 16'd0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/regFileBypass.sv */
`timescale 1ns/10ps
`default_nettype none

module regFileBypass (
	input  logic        clk,
	input  logic        rstN,
	input  logic [2:0]  readSel1,
	input  logic [2:0]  readSel2,
	input  logic [2:0]  writeSel,
	input  logic [15:0] writeData,
	input  logic        writeEn,
	output logic [15:0] readData1,
	output logic [15:0] readData2
);

	logic [7:0][15:0] regs;
	logic hit1;
	logic hit2;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			regs <= '0;
		end else if (writeEn) begin
			regs[writeSel] <= writeData;
		end
	end

	// A read of the register being written sees the new value this cycle
	assign hit1 = writeEn && (readSel1 == writeSel);
	assign hit2 = writeEn && (readSel2 == writeSel);

	assign readData1 = hit1 ? writeData : regs[readSel1];
	assign readData2 = hit2 ? writeData : regs[readSel2];

endmodule

`default_nettype wire

/* hw/branchCompare.sv */
`timescale 1ns/10ps
`default_nettype none

module branchCompare import isaPkg::*; (
	input  logic [15:0] a,
	input  logic [15:0] b,
	input  brSelT       brSel,
	output logic        cond
);

	logic [16:0] sum;

	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		case (brSel)
			brEqz: cond = (a == 16'd0);
			brNez: cond = (a != 16'd0);
			brLtz: cond = a[15];
			brGez: cond = !a[15];
			brEq: cond = (a == b);
			brLt: cond = ($signed(a) < $signed(b));
			brLe: cond = ($signed(a) <= $signed(b));
			default: cond = sum[16];
		endcase
	end

endmodule

`default_nettype wire

/* hw/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
	input  logic        clk,
	input  logic        rstN,
	input  instrU       instr,
	input  logic [15:0] pcInc,
	input  logic [15:0] wbData,
	input  instrU       wbInstr,
	input  logic [1:0]  wbRegDst,
	input  logic        wbRegWrite,
	input  fwdSelT      fwdA,
	input  fwdSelT      fwdB,
	input  logic [15:0] exMemData,
	input  logic [15:0] memWbData,
	output ctrlT        ctrl,
	output decodeOutT   data,
	output logic        cond,
	output logic        err
);

	logic [15:0] readData1;
	logic [15:0] readData2;
	logic [15:0] opA;
	logic [15:0] opB;
	logic [15:0] imm;
	logic [15:0] targetBase;
	logic [2:0] writeSel;

	// EX/MEM is the younger result, so it is checked first
	function automatic logic [15:0] fwdMux(input fwdSelT sel, input logic [15:0] regVal,
			input logic [15:0] exMem, input logic [15:0] memWb);
		return sel.exMem ? exMem : (sel.memWb ? memWb : regVal);
	endfunction

	controlDecoder ctrlDec (
		.opcode(instr.rView.opcode),
		.funct(instr.rView.funct),
		.ctrl(ctrl),
		.err(err)
	);

	immExtender immExt (
		.instr(instr),
		.immKind(ctrl.immKind),
		.imm(imm)
	);

	// Destination comes from the retiring instruction, not the one in decode
	always_comb begin
		case (wbRegDst)
			dstRd: writeSel = wbInstr.rView.rd;
			dstRt: writeSel = wbInstr.rView.rt;
			dstRs: writeSel = wbInstr.rView.rs;
			default: writeSel = 3'd7;
		endcase
	end

	regFileBypass regFile (
		.clk(clk),
		.rstN(rstN),
		.readSel1(instr.rView.rs),
		.readSel2(instr.rView.rt),
		.writeSel(writeSel),
		.writeData(wbData),
		.writeEn(wbRegWrite),
		.readData1(readData1),
		.readData2(readData2)
	);

	assign opA = fwdMux(fwdA, readData1, exMemData, memWbData);
	assign opB = fwdMux(fwdB, readData2, exMemData, memWbData);

	branchCompare brCmp (
		.a(opA),
		.b(opB),
		.brSel(ctrl.brSel),
		.cond(cond)
	);

	// Register jumps add to rs, everything else to the next PC; carry dropped
	assign targetBase = ctrl.jump ? opA : pcInc;

	assign data.opA = opA;
	assign data.opB = readData2;
	assign data.imm = imm;
	assign data.branchPc = imm + targetBase;

endmodule

`default_nettype wire

/* tests/decodeModel.svh */
`ifndef decodeModelSvh
`define decodeModelSvh

// Expected control bundle per opcode with unlisted fields left clear
function automatic ctrlT ctrlForOpcode(input logic [4:0] op, input logic [1:0] fn);
	ctrlT c;
	c = '0;
	case (op)
		HALT: begin
			c.halt = 1'b1;
			c.memDump = 1'b1;
		end
		ADDI, SUBI, ST, LD, STU: begin
			// rs plus signed imm5 through the adder
			c.aluSrc2 = 1'b1;
			c.aluOp = aluAdd;
			c.sign = 1'b1;
			c.regDst = dstRt;
			c.immKind = immSign5;
			case (op)
				ADDI: c.regWrite = 1'b1;
				SUBI: begin
					c.regWrite = 1'b1;
					c.invA = 1'b1;
					c.cin = 1'b1;
				end
				LD: begin
					c.memEn = 1'b1;
					c.memToReg = 1'b1;
					c.regWrite = 1'b1;
				end
				ST: begin
					c.memEn = 1'b1;
					c.memWrite = 1'b1;
				end
				default: begin
					c.memEn = 1'b1;
					c.memWrite = 1'b1;
					c.regWrite = 1'b1;
					c.regDst = dstRs;
				end
			endcase
		end
		XORI, ANDNI, ROLI, SLLI, RORI, SRLI: begin
			c.aluSrc2 = 1'b1;
			c.regWrite = 1'b1;
			c.regDst = dstRt;
			c.immKind = immZero5;
			case (op)
				XORI: c.aluOp = aluXor;
				ANDNI: begin
					c.aluOp = aluAnd;
					c.invB = 1'b1;
				end
				ROLI: c.aluOp = aluRol;
				SLLI: c.aluOp = aluSll;
				RORI: c.aluOp = aluRor;
				default: c.aluOp = aluSrl;
			endcase
		end
		BTR: begin
			c.btr = 1'b1;
			c.regWrite = 1'b1;
		end
		ALUR: begin
			c.regWrite = 1'b1;
			c.aluOp = (fn == 2'd2) ? aluXor : ((fn == 2'd3) ? aluAnd : aluAdd);
			c.sign = (fn < 2'd2);
			c.invA = (fn == 2'd1);
			c.cin = (fn == 2'd1);
			c.invB = (fn == 2'd3);
		end
		SHFR: begin
			c.regWrite = 1'b1;
			c.aluOp = (fn == 2'd0) ? aluRol : (fn == 2'd1) ? aluSll :
				(fn == 2'd2) ? aluRor : aluSrl;
		end
		SEQ, SLT, SLE, SCO: begin
			c.set = 1'b1;
			c.aluOp = aluAdd;
			c.sign = 1'b1;
			c.regWrite = 1'b1;
			c.invB = (op != SCO);
			c.cin = (op != SCO);
			c.brSel = (op == SEQ) ? brEq : (op == SLT) ? brLt : (op == SLE) ? brLe : brCarry;
		end
		BEQZ, BNEZ, BLTZ, BGEZ: begin
			c.pcSrc = 1'b1;
			c.immKind = immSign8;
			c.brSel = (op == BEQZ) ? brEqz : (op == BNEZ) ? brNez :
				(op == BLTZ) ? brLtz : brGez;
		end
		LBI, SLBI: begin
			c.aluSrc2 = 1'b1;
			c.aluOp = aluOr;
			c.regWrite = 1'b1;
			c.regDst = dstRs;
			c.lbi = (op == LBI);
			c.slbi = (op == SLBI);
			c.immKind = (op == LBI) ? immSign8 : immZero8;
		end
		J, JR, JAL, JALR: begin
			c.pcImm = 1'b1;
			c.jump = (op == JR) || (op == JALR);
			c.immKind = c.jump ? immSign8 : immSign11;
			// Linking jumps write the return address to r7
			if (op == JAL || op == JALR) begin
				c.pcToReg = 1'b1;
				c.regWrite = 1'b1;
				c.regDst = dstR7;
			end
		end
		default: begin
		end
	endcase
	return c;
endfunction

function automatic logic isUndefinedOpcode(input logic [4:0] op);
	return (op == 5'b00010) || (op == 5'b00011);
endfunction

function automatic logic [15:0] extendImm(input logic [15:0] w, input immKindT k);
	case (k)
		immSign5: return {{11{w[4]}}, w[4:0]};
		immZero5: return {11'd0, w[4:0]};
		immSign8: return {{8{w[7]}}, w[7:0]};
		immZero8: return {8'd0, w[7:0]};
		immSign11: return {{5{w[10]}}, w[10:0]};
		default: return 16'd0;
	endcase
endfunction

function automatic logic evalCondition(input brSelT s, input logic [15:0] a,
		input logic [15:0] b);
	logic [16:0] total;
	total = a + b;
	case (s)
		brEqz: return a == 16'd0;
		brNez: return a != 16'd0;
		brLtz: return $signed(a) < 0;
		brGez: return $signed(a) >= 0;
		brEq: return a == b;
		brLt: return $signed(a) < $signed(b);
		brLe: return $signed(a) <= $signed(b);
		default: return total[16];
	endcase
endfunction

// 16-bit wrapped target
function automatic logic [15:0] targetSum(input logic [15:0] imm, input logic jump,
		input logic [15:0] opA, input logic [15:0] pcInc);
	logic [15:0] base;
	base = jump ? opA : pcInc;
	return imm + base;
endfunction

`endif

/* tests/decodeTb.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeTb import isaPkg::*, pipePkg::*; ();

	localparam int resetCycles = 3;
	localparam int resetCheckCycles = 8;
	localparam int randomCycles = 2000;
	// Run length plus a quarter for margin
	localparam int timeoutLimit = randomCycles + randomCycles / 4;

	logic clk;
	logic rstN;
	instrU instr;
	logic [15:0] pcInc;
	logic [15:0] wbData;
	instrU wbInstr;
	logic [1:0] wbRegDst;
	logic wbRegWrite;
	fwdSelT fwdA;
	fwdSelT fwdB;
	logic [15:0] exMemData;
	logic [15:0] memWbData;
	ctrlT ctrl;
	decodeOutT data;
	logic cond;
	logic err;

	logic [15:0] shadow [8];
	integer seed;
	int errorCount = 0;
	int cycleCount = 0;

	`include "decodeModel.svh"

	decodeStage DUT (
		.clk(clk),
		.rstN(rstN),
		.instr(instr),
		.pcInc(pcInc),
		.wbData(wbData),
		.wbInstr(wbInstr),
		.wbRegDst(wbRegDst),
		.wbRegWrite(wbRegWrite),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.exMemData(exMemData),
		.memWbData(memWbData),
		.ctrl(ctrl),
		.data(data),
		.cond(cond),
		.err(err)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	task automatic checkValue(input string what, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			errorCount++;
			$display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	// Retiring instruction field picked by its regDst
	function automatic logic [2:0] writeTarget(input logic [15:0] w, input logic [1:0] dst);
		case (dst)
			2'd0: return w[4:2];
			2'd1: return w[7:5];
			2'd2: return w[10:8];
			default: return 3'd7;
		endcase
	endfunction

	// Register read as seen this cycle, with the write bypass
	function automatic logic [15:0] readReg(input logic [2:0] sel);
		if (wbRegWrite && sel == writeTarget(wbInstr, wbRegDst))
			return wbData;
		return shadow[sel];
	endfunction

	function automatic logic [15:0] forwarded(input fwdSelT sel, input logic [15:0] regVal);
		if (sel.exMem)
			return exMemData;
		if (sel.memWb)
			return memWbData;
		return regVal;
	endfunction

	function automatic fwdSelT pickFwd();
		logic [1:0] pick;
		pick = $random(seed);
		// Half the time read straight from the register file
		if ($random(seed) & 1)
			pick = 2'b00;
		return pick;
	endfunction

	// Called at the edge, before new inputs land
	task automatic updateShadow();
		if (wbRegWrite)
			shadow[writeTarget(wbInstr, wbRegDst)] = wbData;
	endtask

	task automatic driveRandom();
		instr <= 16'($random(seed));
		pcInc <= 16'($random(seed));
		wbData <= 16'($random(seed));
		wbInstr <= 16'($random(seed));
		wbRegDst <= 2'($random(seed));
		wbRegWrite <= 1'($random(seed));
		fwdA <= pickFwd();
		fwdB <= pickFwd();
		exMemData <= 16'($random(seed));
		memWbData <= 16'($random(seed));
	endtask

	task automatic checkOutputs();
		ctrlT c;
		logic [15:0] regB;
		logic [15:0] opA;
		logic [15:0] opB;
		logic [15:0] immExp;
		c = ctrlForOpcode(instr[15:11], instr[1:0]);
		regB = readReg(instr[7:5]);
		opA = forwarded(fwdA, readReg(instr[10:8]));
		opB = forwarded(fwdB, regB);
		immExp = extendImm(instr, c.immKind);
		checkValue("ctrl", ctrl, c);
		checkValue("err", err, isUndefinedOpcode(instr[15:11]));
		checkValue("opA", data.opA, opA);
		checkValue("opB", data.opB, regB);
		checkValue("imm", data.imm, immExp);
		checkValue("branchPc", data.branchPc, targetSum(immExp, c.jump, opA, pcInc));
		checkValue("cond", cond, evalCondition(c.brSel, opA, opB));
	endtask

	initial begin
		seed = 70121;
		rstN = 1'b0;
		instr = 16'h0800;
		pcInc = 16'd0;
		wbData = 16'd0;
		wbInstr = 16'd0;
		wbRegDst = 2'd0;
		wbRegWrite = 1'b0;
		fwdA = 2'b00;
		fwdB = 2'b00;
		exMemData = 16'd0;
		memWbData = 16'd0;
		for (int i = 0; i < 8; i++)
			shadow[i] = 16'd0;

		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;

		// Every register reads zero after reset, on both ports
		for (int i = 0; i < resetCheckCycles; i++) begin
			@(posedge clk);
			instr <= {5'b00001, 3'(i), 3'(7 - i), 5'd0};
			#1;
			checkValue("reset read port 1", data.opA, 64'd0);
			checkValue("reset read port 2", data.opB, 64'd0);
			checkOutputs();
		end

		repeat (randomCycles) begin
			@(posedge clk);
			updateShadow();
			driveRandom();
			#1;
			checkOutputs();
		end

		$display("Errors: %0d", errorCount);
		if (errorCount == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+tests
hw/isaPkg.sv
hw/pipePkg.sv
hw/controlDecoder.sv
hw/immExtender.sv
hw/regFileBypass.sv
hw/branchCompare.sv
hw/decodeStage.sv
tests/decodeTb.sv
